// File: src.f
+incdir+src
src/det_data_pkg.sv
src/det_ctrl_pkg.sv
src/det_fsm.sv
src/mul_wait_timer.sv
src/operand_select.sv
src/det_multiplier.sv
src/det_accumulator.sv
src/det_top.sv
test/det_properties.sv
test/det_tb.sv

// File: src/det_accumulator.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module det_accumulator (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  det_ctrl_pkg::step_t    step,
    input  det_data_pkg::product_t product,
    output det_data_pkg::entry_t   chain,
    output det_data_pkg::entry_t   result
);

    // xor of all finished terms, kept at full width
    det_data_pkg::product_t sum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum <= '0;
        end else if (capture) begin
            case (step.acc_op)
                det_ctrl_pkg::ACC_LOAD: begin
                    // clear step loads zero
                    sum <= (step.term == det_ctrl_pkg::TERM_CLEAR) ? '0 : product;
                end
                det_ctrl_pkg::ACC_XOR: begin
                    sum <= sum ^ product;
                end
                default: ;
            endcase
        end
    end

    // first product of a size-3 term, truncated
    always_ff @(posedge clk) begin
        if (capture && step.acc_op == det_ctrl_pkg::ACC_CHAIN) begin
            chain <= product[`DET_ENTRY_W-1:0];
        end
    end

    assign result = sum[`DET_ENTRY_W-1:0];

endmodule

`default_nettype wire

// File: src/det_ctrl_pkg.sv
`default_nettype none

package det_ctrl_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT,
        CAPTURE,
        DONE
    } det_state_e;

    // what the accumulator does with a captured product
    typedef enum logic [1:0] {
        ACC_CHAIN,
        ACC_LOAD,
        ACC_XOR
    } acc_op_e;

    // one entry of the product schedule
    typedef struct packed {
        logic [2:0] term;
        logic       stage;
        acc_op_e    acc_op;
    } step_t;

    // term index outside both tables, loads zero instead of a product
    localparam logic [2:0] TERM_CLEAR = 3'd7;

    // step used for unsupported sizes
    localparam step_t STEP_CLEAR = '{term: TERM_CLEAR, stage: 1'b0, acc_op: ACC_LOAD};

endpackage

`default_nettype wire

// File: src/det_data_pkg.sv
`include "det_macros.svh"
`default_nettype none

package det_data_pkg;

    // one matrix entry, also the width of the result
    typedef logic [`DET_ENTRY_W-1:0] entry_t;

    // full multiplier product
    typedef logic [`DET_PROD_W-1:0] product_t;

    // matrix[row][col], both from 0
    typedef entry_t [`DET_ORDER-1:0][`DET_ORDER-1:0] matrix_t;

    // requested size, only 2 and 3 are computed
    typedef logic [1:0] size_t;

    // operand pair into the multiplier
    typedef struct packed {
        entry_t a;
        entry_t b;
    } mul_operands_t;

endpackage

`default_nettype wire

// File: src/det_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module det_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  det_data_pkg::size_t size,
    input  logic                expired,
    output det_ctrl_pkg::step_t step,
    output logic                issue,
    output logic                capture,
    output logic                done
);

    det_ctrl_pkg::det_state_e state;
    det_ctrl_pkg::step_t      first_step;
    det_ctrl_pkg::step_t      next_step;
    logic                     size2;
    logic                     size3;
    logic                     last_step;

    assign size2 = (size == 2'd2);
    assign size3 = (size == 2'd3);

    // size 2 opens with a direct load
    // size 3 opens with the first half of term 0
    always_comb begin
        first_step.term   = 3'd0;
        first_step.stage  = 1'b0;
        first_step.acc_op = size3 ? det_ctrl_pkg::ACC_CHAIN : det_ctrl_pkg::ACC_LOAD;
    end

    // schedule walk
    always_comb begin
        next_step = step;
        if (size2) begin
            // second single product
            next_step.term   = step.term + 3'd1;
            next_step.acc_op = det_ctrl_pkg::ACC_XOR;
        end else if (!step.stage) begin
            // chained half of the same term
            next_step.stage  = 1'b1;
            next_step.acc_op = (step.term == 3'd0) ? det_ctrl_pkg::ACC_LOAD
                                                   : det_ctrl_pkg::ACC_XOR;
        end else begin
            // first half of the next term
            next_step.term   = step.term + 3'd1;
            next_step.stage  = 1'b0;
            next_step.acc_op = det_ctrl_pkg::ACC_CHAIN;
        end
    end

    assign last_step = (step.term == det_ctrl_pkg::TERM_CLEAR)
                     || (size2 && step.term == 3'd1)
                     || (size3 && step.term == 3'd5 && step.stage);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= det_ctrl_pkg::IDLE;
            step  <= '0;
        end else begin
            case (state)
                det_ctrl_pkg::IDLE: begin
                    if (start) begin
                        if (size2 || size3) begin
                            step  <= first_step;
                            state <= det_ctrl_pkg::ISSUE;
                        end else begin
                            // unsupported size, one zero load then done
                            step  <= det_ctrl_pkg::STEP_CLEAR;
                            state <= det_ctrl_pkg::CAPTURE;
                        end
                    end
                end
                det_ctrl_pkg::ISSUE: begin
                    state <= det_ctrl_pkg::WAIT;
                end
                det_ctrl_pkg::WAIT: begin
                    // product is valid from the expired cycle on
                    if (expired) begin
                        state <= det_ctrl_pkg::CAPTURE;
                    end
                end
                det_ctrl_pkg::CAPTURE: begin
                    if (last_step) begin
                        state <= det_ctrl_pkg::DONE;
                    end else begin
                        step  <= next_step;
                        state <= det_ctrl_pkg::ISSUE;
                    end
                end
                det_ctrl_pkg::DONE: begin
                    // hold until caller drops start
                    if (!start) begin
                        state <= det_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state <= det_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    assign issue   = (state == det_ctrl_pkg::ISSUE);
    assign capture = (state == det_ctrl_pkg::CAPTURE);
    assign done    = (state == det_ctrl_pkg::DONE);

endmodule

`default_nettype wire

// File: src/det_macros.svh
`ifndef DET_MACROS_SVH
`define DET_MACROS_SVH

`default_nettype none

// width of one matrix entry and of the result
`define DET_ENTRY_W 51

// full width of one multiplier product
`define DET_PROD_W 102

// stored matrix order, rows and columns
`define DET_ORDER 3

// multiplier pipeline depth in cycles, at least 2
`define DET_MUL_LAT 4

// wait timer width, must hold DET_MUL_LAT
`define DET_TIMER_W 3

`default_nettype wire

`endif

// File: src/det_multiplier.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module det_multiplier #(
    parameter int STAGES = `DET_MUL_LAT
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  det_data_pkg::mul_operands_t operands,
    output det_data_pkg::product_t      product
);

    // operand register counts as the first stage
    det_data_pkg::mul_operands_t op_q;
    det_data_pkg::product_t      pipe [STAGES-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_q <= '0;
            for (int i = 0; i < STAGES - 1; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            // operands held between issues, output stays stable
            if (issue) begin
                op_q <= operands;
            end
            // full-width multiply, 102-bit context
            pipe[0] <= op_q.a * op_q.b;
            for (int i = 1; i < STAGES - 1; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // valid STAGES cycles after issue
    assign product = pipe[STAGES-2];

endmodule

`default_nettype wire

// File: src/det_top.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module det_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  det_data_pkg::size_t   size,
    input  det_data_pkg::matrix_t matrix,
    output det_data_pkg::entry_t  result,
    output logic                  done
);

    // sequencer to datapath
    det_ctrl_pkg::step_t         step;
    logic                        issue;
    logic                        capture;
    logic                        expired;

    // datapath
    det_data_pkg::mul_operands_t operands;
    det_data_pkg::product_t      product;
    det_data_pkg::entry_t        chain;

    det_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .size    (size),
        .expired (expired),
        .step    (step),
        .issue   (issue),
        .capture (capture),
        .done    (done)
    );

    // same latency as the multiplier below
    mul_wait_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .expired (expired)
    );

    operand_select u_sel (
        .matrix   (matrix),
        .size     (size),
        .step     (step),
        .chain    (chain),
        .operands (operands)
    );

    det_multiplier #(
        .STAGES (`DET_MUL_LAT)
    ) u_mul (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .operands (operands),
        .product  (product)
    );

    det_accumulator u_acc (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .step    (step),
        .product (product),
        .chain   (chain),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: src/mul_wait_timer.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module mul_wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic issue,
    output logic expired
);

    // cycles since issue, zero when idle
    logic [`DET_TIMER_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (issue) begin
            count <= `DET_TIMER_W'(1);
        end else if (count == `DET_TIMER_W'(`DET_MUL_LAT)) begin
            count <= '0;
        end else if (count != '0) begin
            count <= count + `DET_TIMER_W'(1);
        end
    end

    // one cycle, same cycle the multiplier output turns valid
    assign expired = (count == `DET_TIMER_W'(`DET_MUL_LAT));

endmodule

`default_nettype wire

// File: src/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  det_data_pkg::matrix_t       matrix,
    input  det_data_pkg::size_t         size,
    input  det_ctrl_pkg::step_t         step,
    input  det_data_pkg::entry_t        chain,
    output det_data_pkg::mul_operands_t operands
);

    // the three factors of the current term
    det_data_pkg::entry_t f0;
    det_data_pkg::entry_t f1;
    det_data_pkg::entry_t f2;

    always_comb begin
        f0 = '0;
        f1 = '0;
        f2 = '0;
        if (size == 2'd2) begin
            // two single products, no third factor
            case (step.term)
                3'd0: begin
                    f0 = matrix[0][0];
                    f1 = matrix[1][1];
                end
                3'd1: begin
                    f0 = matrix[0][1];
                    f1 = matrix[1][0];
                end
                default: ;
            endcase
        end else if (size == 2'd3) begin
            // sarrus order, three positive diagonals then three negative
            case (step.term)
                3'd0: begin
                    f0 = matrix[0][0];
                    f1 = matrix[1][1];
                    f2 = matrix[2][2];
                end
                3'd1: begin
                    f0 = matrix[0][1];
                    f1 = matrix[1][2];
                    f2 = matrix[2][0];
                end
                3'd2: begin
                    f0 = matrix[0][2];
                    f1 = matrix[1][0];
                    f2 = matrix[2][1];
                end
                3'd3: begin
                    f0 = matrix[0][2];
                    f1 = matrix[1][1];
                    f2 = matrix[2][0];
                end
                3'd4: begin
                    f0 = matrix[0][1];
                    f1 = matrix[1][0];
                    f2 = matrix[2][2];
                end
                3'd5: begin
                    f0 = matrix[0][0];
                    f1 = matrix[1][2];
                    f2 = matrix[2][1];
                end
                default: ;
            endcase
        end
    end

    // chained stage reuses the truncated first product
    assign operands.a = step.stage ? chain : f0;
    assign operands.b = step.stage ? f2 : f1;

endmodule

`default_nettype wire

// File: test/det_properties.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module det_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     issue,
    input logic                     capture,
    input logic                     expired,
    input logic                     done,
    input det_ctrl_pkg::det_state_e state
);

    // number of failed assertions
    int fail_count = 0;

    // no capture in the issue cycle nor before the multiplier latency has passed
    a_issue_capture_apart : assert property (
        @(posedge clk) disable iff (rst)
        issue |-> !capture [*`DET_MUL_LAT + 1]
    ) else begin
        $error("capture sooner than the multiplier latency after issue");
        fail_count++;
    end

    // first edge after reset release
    a_done_low_after_reset : assert property (
        @(posedge clk)
        $fell(rst) |-> !done
    ) else begin
        $error("done high in the cycle after reset");
        fail_count++;
    end

    // timer pulse only while the sequencer waits for it
    a_expired_in_wait : assert property (
        @(posedge clk) disable iff (rst)
        expired |-> (state == det_ctrl_pkg::WAIT)
    ) else begin
        $error("expired outside the WAIT state");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: test/det_tb.sv
`timescale 1ns/1ps
`include "det_macros.svh"
`default_nettype none

module det_tb;

    // 40 worst-case size-3 requests plus slack
    localparam int CYCLE_LIMIT = 40 * (12 * (`DET_MUL_LAT + 2) + 10) + 1000;

    logic                  clk;
    logic                  rst;
    logic                  start;
    det_data_pkg::size_t   size;
    det_data_pkg::matrix_t matrix;
    det_data_pkg::entry_t  result;
    logic                  done;

    logic [31:0] lfsr;
    int          cycle_count;
    int          checks;
    int          result_errors;
    int          done_errors;
    int          assert_errors;

    det_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .size   (size),
        .matrix (matrix),
        .result (result),
        .done   (done)
    );

    bind det_fsm det_properties props0 (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .capture (capture),
        .expired (expired),
        .done    (done),
        .state   (state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic random_entry(output det_data_pkg::entry_t e);
        e = '0;
        for (int i = 0; i < `DET_ENTRY_W; i++) begin
            lfsr = lfsr_next(lfsr);
            e = {e[`DET_ENTRY_W-2:0], lfsr[0]};
        end
    endtask

    task automatic random_matrix(output det_data_pkg::matrix_t m);
        det_data_pkg::entry_t e;
        for (int r = 0; r < `DET_ORDER; r++) begin
            for (int c = 0; c < `DET_ORDER; c++) begin
                random_entry(e);
                m[r][c] = e;
            end
        end
    endtask

    // leibniz terms xored, size-3 first product cut to entry width
    function automatic det_data_pkg::entry_t expected_det(input det_data_pkg::size_t sz,
                                                          input det_data_pkg::matrix_t m);
        logic [`DET_PROD_W-1:0] acc;
        logic [`DET_PROD_W-1:0] p;
        det_data_pkg::entry_t   t;
        acc = '0;
        if (sz == 2'd2) begin
            p = m[0][0] * m[1][1];
            acc = p;
            p = m[0][1] * m[1][0];
            acc = acc ^ p;
        end else if (sz == 2'd3) begin
            for (int j = 0; j < 3; j++) begin
                // rising diagonal from column j
                p = m[0][j] * m[1][(j + 1) % 3];
                t = p[`DET_ENTRY_W-1:0];
                p = t * m[2][(j + 2) % 3];
                acc = acc ^ p;
                // falling diagonal from column j
                p = m[0][j] * m[1][(j + 2) % 3];
                t = p[`DET_ENTRY_W-1:0];
                p = t * m[2][(j + 1) % 3];
                acc = acc ^ p;
            end
        end
        return acc[`DET_ENTRY_W-1:0];
    endfunction

    task automatic check_result(input det_data_pkg::entry_t got,
                                input det_data_pkg::entry_t expected, input string what);
        checks++;
        if (got !== expected) begin
            result_errors++;
            $display("Fail at %0t ns: %s result %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_done(input logic got, input logic expected, input string what);
        checks++;
        if (got !== expected) begin
            done_errors++;
            $display("Fail at %0t ns: %s done %b, expected %b", $time, what, got, expected);
        end
    endtask

    // start level held until done, then dropped
    task automatic run_request(input det_data_pkg::size_t sz, input det_data_pkg::matrix_t m,
                               input int hold_cycles, input string what);
        det_data_pkg::entry_t expected;
        expected = expected_det(sz, m);
        @(posedge clk);
        start  <= 1'b1;
        size   <= sz;
        matrix <= m;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        check_result(result, expected, what);
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_done(done, 1'b1, {what, " held"});
            check_result(result, expected, {what, " held"});
        end
        @(posedge clk);
        start <= 1'b0;
        // fsm still sees start high on this edge
        @(negedge clk);
        check_done(done, 1'b1, {what, " start drop"});
        @(negedge clk);
        check_done(done, 1'b0, {what, " after start drop"});
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Cycle limit of %0d reached before all requests finished.", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        det_data_pkg::matrix_t m;
        lfsr          = 32'd24;
        checks        = 0;
        result_errors = 0;
        done_errors   = 0;
        assert_errors = 0;
        rst           = 1'b1;
        start         = 1'b0;
        size          = '0;
        matrix        = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_done(done, 1'b0, "after reset");
        check_result(result, '0, "after reset");

        for (int i = 0; i < 20; i++) begin
            random_matrix(m);
            run_request(2'd2, m, 0, $sformatf("size-2 matrix %0d", i));
        end
        for (int i = 0; i < 20; i++) begin
            random_matrix(m);
            run_request(2'd3, m, 0, $sformatf("size-3 matrix %0d", i));
        end

        // widest operands, truncation and full xor width
        m = '1;
        run_request(2'd3, m, 0, "all-ones size-3");
        run_request(2'd2, m, 0, "all-ones size-2");

        // long hold, then a fresh request
        random_matrix(m);
        run_request(2'd3, m, 6, "held size-3");
        random_matrix(m);
        run_request(2'd3, m, 0, "second size-3");

        // unsupported sizes clear a nonzero result
        run_request(2'd0, m, 0, "size 0");
        random_matrix(m);
        run_request(2'd2, m, 0, "size-2 before size 1");
        run_request(2'd1, m, 0, "size 1");

        // bound checker on the sequencer
        assert_errors = dut0.u_fsm.props0.fail_count;

        $display("checks %0d, result errors %0d, done errors %0d, assertion errors %0d",
                 checks, result_errors, done_errors, assert_errors);
        if (result_errors == 0 && done_errors == 0 && assert_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
